// File: src/hb_pkg.sv
package hb_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and payload types
  ////////////////////////////////////////////////////////////////////////////

  localparam int ADDR_W    = 8;
  localparam int DATA_W    = 16;
  localparam int OP_W      = 2;
  localparam int CORD_W    = 4;
  localparam int MEM_IDX_W = 4;
  localparam int TAG_ID_W  = 2;

  typedef logic [ADDR_W-1:0]    hb_addr_t;
  typedef logic [DATA_W-1:0]    hb_data_t;
  typedef logic [OP_W-1:0]      hb_op_t;
  typedef logic [CORD_W-1:0]    hb_cord_t;
  typedef logic [MEM_IDX_W-1:0] hb_mem_idx_t;
  typedef logic [TAG_ID_W-1:0]  tag_client_t;

  ////////////////////////////////////////////////////////////////////////////
  // Tag line
  ////////////////////////////////////////////////////////////////////////////

  // Frame is the client id then the payload, LSB first
  localparam int TAG_PAYLOAD_W = 8;
  localparam int TAG_FRAME_LEN = TAG_ID_W + TAG_PAYLOAD_W;

  localparam tag_client_t TAG_CORE_RESET = 2'd0;
  localparam tag_client_t TAG_WEST_CORD  = 2'd1;
  localparam tag_client_t TAG_EAST_CORD  = 2'd2;

  ////////////////////////////////////////////////////////////////////////////
  // Requests and address decode
  ////////////////////////////////////////////////////////////////////////////

  // Remaining codes only travel on remote flits
  localparam hb_op_t OP_LOAD  = 2'd0;
  localparam hb_op_t OP_STORE = 2'd1;

  localparam int MEM_WORDS     = 2 ** MEM_IDX_W;
  // Local when these upper bits are all zero
  localparam int LOCAL_SEL_MSB = ADDR_W - 1;
  localparam int LOCAL_SEL_LSB = MEM_IDX_W;
  localparam int EAST_ADDR_BIT = 7;

  // Link buffers
  localparam int BUF_DEPTH = 2;
  localparam int BUF_PTR_W = $clog2(BUF_DEPTH);
  localparam int BUF_CNT_W = $clog2(BUF_DEPTH + 1);

  // Egress lanes share one buffer layout sized for a flit
  localparam int FLIT_W    = CORD_W + OP_W + ADDR_W + DATA_W;
  localparam int EGR_LANES = 2;
  localparam int LANE_RSP  = 0;
  localparam int LANE_MEM  = 1;

endpackage

// File: src/hb_link_if.sv
// Request from the ingress buffer into the pod
interface hb_req_if;
  import hb_pkg::*;

  logic     valid;
  logic     ready;
  hb_op_t   op;
  hb_addr_t addr;
  hb_data_t data;

  modport src (
    output valid,
    input  ready,
    output op,
    output addr,
    output data
  );

  modport dst (
    input  valid,
    output ready,
    input  op,
    input  addr,
    input  data
  );
endinterface

// Remote flit from the pod toward the memory link
interface hb_flit_if;
  import hb_pkg::*;

  logic     valid;
  logic     ready;
  hb_cord_t cord;
  hb_op_t   op;
  hb_addr_t addr;
  hb_data_t data;

  modport src (output valid, input ready, output cord, output op, output addr, output data);
  modport dst (input valid, output ready, input cord, input op, input addr, input data);
endinterface

// File: src/hb_tag_client.sv
module hb_tag_client
  (input                     hb_clk_i
  ,input                     rst_n_i
  ,input                     tag_valid_i
  ,input                     tag_data_i
  ,output logic              core_reset_o
  ,output hb_pkg::hb_cord_t  west_cord_o
  ,output hb_pkg::hb_cord_t  east_cord_o
  );

  import hb_pkg::*;

  typedef enum logic [1:0] {
    TAG_IDLE,
    TAG_SHIFT,
    TAG_APPLY
  } tag_state_t;

  typedef logic [$clog2(TAG_FRAME_LEN+1)-1:0] bit_cnt_t;

  tag_state_t               state_q;
  bit_cnt_t                 bit_cnt_q;
  logic [TAG_FRAME_LEN-1:0] frame_q;
  logic [TAG_FRAME_LEN-1:0] frame_shifted;
  tag_client_t              frame_id;
  logic [TAG_PAYLOAD_W-1:0] frame_payload;

  // LSB arrives first, so bits enter at the top
  assign frame_shifted = {tag_data_i, frame_q[TAG_FRAME_LEN-1:1]};
  assign frame_id      = frame_q[TAG_ID_W-1:0];
  assign frame_payload = frame_q[TAG_FRAME_LEN-1:TAG_ID_W];

  always_ff @(posedge hb_clk_i) begin
    if (tag_valid_i) begin
      frame_q <= frame_shifted;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Frame FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge hb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= TAG_IDLE;
      bit_cnt_q <= '0;
    end else begin
      case (state_q)
        TAG_IDLE, TAG_APPLY: begin
          // A new frame may start right behind the one being applied
          if (tag_valid_i) begin
            state_q   <= TAG_SHIFT;
            bit_cnt_q <= bit_cnt_t'(1);
          end else begin
            state_q   <= TAG_IDLE;
            bit_cnt_q <= '0;
          end
        end
        TAG_SHIFT: begin
          if (!tag_valid_i) begin
            // Cut short, drop it
            state_q   <= TAG_IDLE;
            bit_cnt_q <= '0;
          end else begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == bit_cnt_t'(TAG_FRAME_LEN - 1)) begin
              state_q <= TAG_APPLY;
            end
          end
        end
        default: begin
          state_q   <= TAG_IDLE;
          bit_cnt_q <= '0;
        end
      endcase
    end
  end

  // Client registers, core held in reset until released by tag
  always_ff @(posedge hb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      core_reset_o <= 1'b1;
      west_cord_o  <= '0;
      east_cord_o  <= '0;
    end else if (state_q == TAG_APPLY) begin
      case (frame_id)
        TAG_CORE_RESET: core_reset_o <= frame_payload[0];
        TAG_WEST_CORD:  west_cord_o  <= frame_payload[CORD_W-1:0];
        TAG_EAST_CORD:  east_cord_o  <= frame_payload[CORD_W-1:0];
        default: ;
      endcase
    end
  end

  a_bit_cnt_range: assert property (@(posedge hb_clk_i) disable iff (!rst_n_i)
    bit_cnt_q <= bit_cnt_t'(TAG_FRAME_LEN));

endmodule

// File: src/hb_link_ingress.sv
module hb_link_ingress
  (input                     hb_clk_i
  ,input                     rst_n_i
  ,input                     core_reset_i
  ,input                     req_valid_i
  ,output logic              req_ready_o
  ,input  hb_pkg::hb_op_t    req_op_i
  ,input  hb_pkg::hb_addr_t  req_addr_i
  ,input  hb_pkg::hb_data_t  req_data_i
  ,hb_req_if.src             req
  );

  import hb_pkg::*;

  hb_op_t               op_q   [BUF_DEPTH];
  hb_addr_t             addr_q [BUF_DEPTH];
  hb_data_t             data_q [BUF_DEPTH];
  logic [BUF_PTR_W-1:0] wr_ptr_q;
  logic [BUF_PTR_W-1:0] rd_ptr_q;
  logic [BUF_CNT_W-1:0] count_q;
  logic                 push;
  logic                 pop;

  // Host is held off while the core sits in reset
  assign req_ready_o = (count_q < BUF_CNT_W'(BUF_DEPTH)) && !core_reset_i;
  assign push        = req_valid_i && req_ready_o;
  assign pop         = req.valid && req.ready;

  assign req.valid = (count_q != '0);
  assign req.op    = op_q[rd_ptr_q];
  assign req.addr  = addr_q[rd_ptr_q];
  assign req.data  = data_q[rd_ptr_q];

  always_ff @(posedge hb_clk_i) begin
    if (push) begin
      op_q[wr_ptr_q]   <= req_op_i;
      addr_q[wr_ptr_q] <= req_addr_i;
      data_q[wr_ptr_q] <= req_data_i;
    end
  end

  always_ff @(posedge hb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (core_reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  // Pointers meet with entries held only when every slot is taken
  a_no_push_full: assert property (@(posedge hb_clk_i) disable iff (!rst_n_i)
    push |-> !(wr_ptr_q == rd_ptr_q && count_q != '0));

endmodule

// File: src/hb_tile_pod.sv
module hb_tile_pod
  (input                     hb_clk_i
  ,input                     rst_n_i
  ,input                     core_reset_i
  ,input  hb_pkg::hb_cord_t  west_cord_i
  ,input  hb_pkg::hb_cord_t  east_cord_i
  ,hb_req_if.dst             req
  ,hb_flit_if.src            flit
  ,output logic              rsp_valid_o
  ,input                     rsp_ready_i
  ,output hb_pkg::hb_data_t  rsp_data_o
  );

  import hb_pkg::*;

  hb_data_t    mem_q [MEM_WORDS];
  hb_mem_idx_t mem_idx;
  logic        is_local;
  logic        is_load;
  logic        is_store;
  logic        req_fire;
  logic        store_fire;

  ////////////////////////////////////////////////////////////////////////////
  // Request decode
  ////////////////////////////////////////////////////////////////////////////

  assign mem_idx  = req.addr[MEM_IDX_W-1:0];
  assign is_local = (req.addr[LOCAL_SEL_MSB:LOCAL_SEL_LSB] == '0);
  assign is_load  = (req.op == OP_LOAD);
  assign is_store = (req.op == OP_STORE);

  // Ready follows whichever side the request is headed for
  always_comb begin
    if (core_reset_i) begin
      req.ready = 1'b0;
    end else if (!is_local) begin
      req.ready = flit.ready;
    end else if (is_load) begin
      req.ready = rsp_ready_i;
    end else begin
      // Local stores, and unknown local ops which are dropped
      req.ready = 1'b1;
    end
  end

  assign req_fire   = req.valid && req.ready;
  assign store_fire = req_fire && is_local && is_store;

  ////////////////////////////////////////////////////////////////////////////
  // Scratch memory
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge hb_clk_i) begin
    if (core_reset_i) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (store_fire) begin
      mem_q[mem_idx] <= req.data;
    end
  end

  // Load data is read in the accepting cycle
  assign rsp_valid_o = req.valid && is_local && is_load && !core_reset_i;
  assign rsp_data_o  = mem_q[mem_idx];

  ////////////////////////////////////////////////////////////////////////////
  // Remote flits
  ////////////////////////////////////////////////////////////////////////////

  assign flit.valid = req.valid && !is_local && !core_reset_i;
  assign flit.cord  = req.addr[EAST_ADDR_BIT] ? east_cord_i : west_cord_i;
  assign flit.op    = req.op;
  assign flit.addr  = req.addr;
  assign flit.data  = req.data;

  // Ingress is flushed on the way out of core reset as well
  a_no_store_in_reset: assert property (@(posedge hb_clk_i) disable iff (!rst_n_i)
    store_fire |-> !core_reset_i && !$past(core_reset_i));

endmodule

// File: src/hb_link_egress.sv
module hb_link_egress
  (input                     hb_clk_i
  ,input                     rst_n_i
  ,input                     core_reset_i
  ,hb_flit_if.dst            flit
  ,input                     rsp_valid_i
  ,output logic              rsp_ready_o
  ,input  hb_pkg::hb_data_t  rsp_data_i
  ,output logic              rsp_valid_o
  ,input                     rsp_ready_i
  ,output hb_pkg::hb_data_t  rsp_data_o
  ,output logic              mem_valid_o
  ,input                     mem_ready_i
  ,output hb_pkg::hb_cord_t  mem_cord_o
  ,output hb_pkg::hb_op_t    mem_op_o
  ,output hb_pkg::hb_addr_t  mem_addr_o
  ,output hb_pkg::hb_data_t  mem_data_o
  );

  import hb_pkg::*;

  logic [EGR_LANES-1:0]             in_valid;
  logic [EGR_LANES-1:0]             in_ready;
  logic [EGR_LANES-1:0][FLIT_W-1:0] in_data;
  logic [EGR_LANES-1:0]             out_valid;
  logic [EGR_LANES-1:0]             out_ready;
  logic [EGR_LANES-1:0][FLIT_W-1:0] out_data;

  ////////////////////////////////////////////////////////////////////////////
  // Lane mapping
  ////////////////////////////////////////////////////////////////////////////

  // Responses ride in the data field of a flit-sized slot
  assign in_valid[LANE_RSP]  = rsp_valid_i;
  assign in_data[LANE_RSP]   = FLIT_W'(rsp_data_i);
  assign rsp_ready_o         = in_ready[LANE_RSP];
  assign rsp_valid_o         = out_valid[LANE_RSP];
  assign rsp_data_o          = out_data[LANE_RSP][DATA_W-1:0];
  assign out_ready[LANE_RSP] = rsp_ready_i;

  assign in_valid[LANE_MEM]  = flit.valid;
  assign in_data[LANE_MEM]   = {flit.cord, flit.op, flit.addr, flit.data};
  assign flit.ready          = in_ready[LANE_MEM];
  assign mem_valid_o         = out_valid[LANE_MEM];
  assign out_ready[LANE_MEM] = mem_ready_i;
  assign {mem_cord_o, mem_op_o, mem_addr_o, mem_data_o} = out_data[LANE_MEM];

  ////////////////////////////////////////////////////////////////////////////
  // Two-entry buffer per lane
  ////////////////////////////////////////////////////////////////////////////

  for (genvar l = 0; l < EGR_LANES; l++) begin : g_lane
    logic [FLIT_W-1:0]    slot_q [BUF_DEPTH];
    logic [BUF_PTR_W-1:0] wr_ptr_q;
    logic [BUF_PTR_W-1:0] rd_ptr_q;
    logic [BUF_CNT_W-1:0] count_q;
    logic                 push;
    logic                 pop;

    assign in_ready[l]  = (count_q < BUF_CNT_W'(BUF_DEPTH));
    assign out_valid[l] = (count_q != '0);
    assign out_data[l]  = slot_q[rd_ptr_q];
    assign push         = in_valid[l] && in_ready[l];
    assign pop          = out_valid[l] && out_ready[l];

    always_ff @(posedge hb_clk_i) begin
      if (push) begin
        slot_q[wr_ptr_q] <= in_data[l];
      end
    end

    always_ff @(posedge hb_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
      end else if (core_reset_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
      end else begin
        if (push) begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
        if (pop) begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
        case ({push, pop})
          2'b10:   count_q <= count_q + 1'b1;
          2'b01:   count_q <= count_q - 1'b1;
          default: ;
        endcase
      end
    end
  end

  a_mem_hold: assert property (@(posedge hb_clk_i) disable iff (!rst_n_i)
    mem_valid_o && !mem_ready_i && !core_reset_i |=>
      mem_valid_o && $stable({mem_cord_o, mem_op_o, mem_addr_o, mem_data_o}));

endmodule

// File: src/hb_core_complex.sv
module hb_core_complex
  (input                     hb_clk_i
  ,input                     rst_n_i

  ,input                     tag_valid_i
  ,input                     tag_data_i

  ,input                     req_valid_i
  ,output logic              req_ready_o
  ,input  hb_pkg::hb_op_t    req_op_i
  ,input  hb_pkg::hb_addr_t  req_addr_i
  ,input  hb_pkg::hb_data_t  req_data_i

  ,output logic              rsp_valid_o
  ,input                     rsp_ready_i
  ,output hb_pkg::hb_data_t  rsp_data_o

  ,output logic              mem_valid_o
  ,input                     mem_ready_i
  ,output hb_pkg::hb_cord_t  mem_cord_o
  ,output hb_pkg::hb_op_t    mem_op_o
  ,output hb_pkg::hb_addr_t  mem_addr_o
  ,output hb_pkg::hb_data_t  mem_data_o
  );

  import hb_pkg::*;

  logic     core_reset;
  hb_cord_t west_cord;
  hb_cord_t east_cord;

  // Load responses from pod to egress
  logic     pod_rsp_valid;
  logic     pod_rsp_ready;
  hb_data_t pod_rsp_data;

  hb_req_if  req_if ();
  hb_flit_if flit_if ();

  ////////////////////////////////////////////////////////////////////////////
  // Input side
  ////////////////////////////////////////////////////////////////////////////

  hb_tag_client tag_client
    (.hb_clk_i     (hb_clk_i)
    ,.rst_n_i      (rst_n_i)
    ,.tag_valid_i  (tag_valid_i)
    ,.tag_data_i   (tag_data_i)
    ,.core_reset_o (core_reset)
    ,.west_cord_o  (west_cord)
    ,.east_cord_o  (east_cord)
    );

  hb_link_ingress ingress
    (.hb_clk_i     (hb_clk_i)
    ,.rst_n_i      (rst_n_i)
    ,.core_reset_i (core_reset)
    ,.req_valid_i  (req_valid_i)
    ,.req_ready_o  (req_ready_o)
    ,.req_op_i     (req_op_i)
    ,.req_addr_i   (req_addr_i)
    ,.req_data_i   (req_data_i)
    ,.req          (req_if.src)
    );

  ////////////////////////////////////////////////////////////////////////////
  // Pod and output side
  ////////////////////////////////////////////////////////////////////////////

  hb_tile_pod pod
    (.hb_clk_i     (hb_clk_i)
    ,.rst_n_i      (rst_n_i)
    ,.core_reset_i (core_reset)
    ,.west_cord_i  (west_cord)
    ,.east_cord_i  (east_cord)
    ,.req          (req_if.dst)
    ,.flit         (flit_if.src)
    ,.rsp_valid_o  (pod_rsp_valid)
    ,.rsp_ready_i  (pod_rsp_ready)
    ,.rsp_data_o   (pod_rsp_data)
    );

  hb_link_egress egress
    (.hb_clk_i     (hb_clk_i)
    ,.rst_n_i      (rst_n_i)
    ,.core_reset_i (core_reset)
    ,.flit         (flit_if.dst)
    ,.rsp_valid_i  (pod_rsp_valid)
    ,.rsp_ready_o  (pod_rsp_ready)
    ,.rsp_data_i   (pod_rsp_data)
    ,.rsp_valid_o  (rsp_valid_o)
    ,.rsp_ready_i  (rsp_ready_i)
    ,.rsp_data_o   (rsp_data_o)
    ,.mem_valid_o  (mem_valid_o)
    ,.mem_ready_i  (mem_ready_i)
    ,.mem_cord_o   (mem_cord_o)
    ,.mem_op_o     (mem_op_o)
    ,.mem_addr_o   (mem_addr_o)
    ,.mem_data_o   (mem_data_o)
    );

endmodule

// File: verif/tb_hb_core_complex.sv
module tb_hb_core_complex;
  timeunit 1ns;
  timeprecision 1ps;

  import hb_pkg::*;

  localparam int KIND_NONE = 0;
  localparam int KIND_RSP  = 1;
  localparam int KIND_FLIT = 2;

  // Phase boundaries in the request table
  localparam int A_LO = 0;
  localparam int A_HI = 6;
  localparam int B_HI = 10;
  localparam int C_HI = 22;
  localparam int D_MID = 23;
  localparam int D_HI = 25;
  localparam int N_ROWS = 42;
  localparam int WATCHDOG_CYCLES = 40 * N_ROWS + 200;

  logic     hb_clk_i;
  logic     rst_n_i;
  logic     tag_valid_i;
  logic     tag_data_i;
  logic     req_valid_i;
  logic     req_ready_o;
  hb_op_t   req_op_i;
  hb_addr_t req_addr_i;
  hb_data_t req_data_i;
  logic     rsp_valid_o;
  logic     rsp_ready_i;
  hb_data_t rsp_data_o;
  logic     mem_valid_o;
  logic     mem_ready_i;
  hb_cord_t mem_cord_o;
  hb_op_t   mem_op_o;
  hb_addr_t mem_addr_o;
  hb_data_t mem_data_o;

  hb_op_t   tbl_op   [N_ROWS];
  hb_addr_t tbl_addr [N_ROWS];
  hb_data_t tbl_data [N_ROWS];
  int       tbl_kind [N_ROWS];
  int       tbl_n;

  // Reference state
  hb_data_t          model_mem [MEM_WORDS];
  hb_cord_t          west_model;
  hb_cord_t          east_model;
  hb_data_t          rsp_q[$];
  logic [FLIT_W-1:0] flit_q[$];

  integer   seed;
  int       err_mismatch;
  int       err_other;
  logic     bp_en;
  int       rsp_burst;
  int       mem_burst;
  hb_data_t rsp_exp;
  hb_cord_t exp_cord;
  hb_op_t   exp_op;
  hb_addr_t exp_addr;
  hb_data_t exp_data;

  hb_core_complex i_dut (
    .hb_clk_i    (hb_clk_i),
    .rst_n_i     (rst_n_i),
    .tag_valid_i (tag_valid_i),
    .tag_data_i  (tag_data_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_op_i    (req_op_i),
    .req_addr_i  (req_addr_i),
    .req_data_i  (req_data_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_data_o  (rsp_data_o),
    .mem_valid_o (mem_valid_o),
    .mem_ready_i (mem_ready_i),
    .mem_cord_o  (mem_cord_o),
    .mem_op_o    (mem_op_o),
    .mem_addr_o  (mem_addr_o),
    .mem_data_o  (mem_data_o)
  );

  always #20 hb_clk_i = ~hb_clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Table and reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic void add_row(input hb_op_t op, input hb_addr_t addr, input int kind);
    tbl_op[tbl_n]   = op;
    tbl_addr[tbl_n] = addr;
    tbl_data[tbl_n] = hb_data_t'($random(seed));
    tbl_kind[tbl_n] = kind;
    tbl_n++;
  endfunction

  function automatic void build_table();
    tbl_n = 0;
    add_row(OP_STORE, 8'h03, KIND_NONE);
    add_row(OP_STORE, 8'h0A, KIND_NONE);
    add_row(OP_LOAD,  8'h03, KIND_RSP);
    add_row(OP_LOAD,  8'h0A, KIND_RSP);
    // Never written
    add_row(OP_LOAD,  8'h05, KIND_RSP);
    add_row(OP_STORE, 8'h03, KIND_NONE);
    add_row(OP_LOAD,  8'h03, KIND_RSP);
    add_row(OP_STORE, 8'h85, KIND_FLIT);
    add_row(OP_LOAD,  8'h42, KIND_FLIT);
    add_row(2'd2,     8'h97, KIND_FLIT);
    add_row(2'd3,     8'h10, KIND_FLIT);
    // Mixed traffic under back-pressure
    add_row(OP_STORE, 8'h01, KIND_NONE);
    add_row(OP_STORE, 8'h81, KIND_FLIT);
    add_row(OP_LOAD,  8'h01, KIND_RSP);
    add_row(OP_LOAD,  8'h22, KIND_FLIT);
    add_row(OP_LOAD,  8'h0A, KIND_RSP);
    add_row(OP_STORE, 8'h0F, KIND_NONE);
    add_row(2'd2,     8'hF0, KIND_FLIT);
    add_row(OP_LOAD,  8'h0F, KIND_RSP);
    add_row(OP_LOAD,  8'h03, KIND_RSP);
    add_row(2'd3,     8'h40, KIND_FLIT);
    add_row(OP_STORE, 8'h01, KIND_NONE);
    add_row(OP_LOAD,  8'h01, KIND_RSP);
    add_row(OP_STORE, 8'hA4, KIND_FLIT);
    add_row(OP_LOAD,  8'hE8, KIND_FLIT);
    add_row(OP_STORE, 8'h31, KIND_FLIT);
    for (int w = 0; w < MEM_WORDS; w++) begin
      add_row(OP_LOAD, hb_addr_t'(w), KIND_RSP);
    end
  endfunction

  function automatic void expect_row(input int i);
    int kind;
    if (tbl_addr[i][ADDR_W-1:MEM_IDX_W] != '0) begin
      kind = KIND_FLIT;
    end else if (tbl_op[i] == OP_LOAD) begin
      kind = KIND_RSP;
    end else begin
      kind = KIND_NONE;
    end
    if (kind != tbl_kind[i]) begin
      err_other++;
      $display("row %0d is listed as kind %0d but decodes as kind %0d", i, tbl_kind[i], kind);
    end
    if (kind == KIND_FLIT) begin
      flit_q.push_back({tbl_addr[i][EAST_ADDR_BIT] ? east_model : west_model,
                        tbl_op[i], tbl_addr[i], tbl_data[i]});
    end else if (kind == KIND_RSP) begin
      rsp_q.push_back(model_mem[tbl_addr[i][MEM_IDX_W-1:0]]);
    end else begin
      model_mem[tbl_addr[i][MEM_IDX_W-1:0]] = tbl_data[i];
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks, entered and left on a rising edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_tag(input tag_client_t id, input logic [7:0] payload, input int nbits);
    logic [TAG_FRAME_LEN-1:0] frame;
    frame = {payload, id};
    for (int i = 0; i < nbits; i++) begin
      tag_valid_i <= 1'b1;
      tag_data_i  <= frame[i];
      @(posedge hb_clk_i);
    end
    tag_valid_i <= 1'b0;
    tag_data_i  <= 1'b0;
    repeat (3) @(posedge hb_clk_i);
    if (nbits == TAG_FRAME_LEN) begin
      case (id)
        TAG_CORE_RESET: begin
          if (payload[0]) begin
            for (int w = 0; w < MEM_WORDS; w++) begin
              model_mem[w] = '0;
            end
          end
        end
        TAG_WEST_CORD: west_model = payload[3:0];
        TAG_EAST_CORD: east_model = payload[3:0];
        default: ;
      endcase
    end
  endtask

  task automatic apply_rows(input int first, input int last);
    logic accepted;
    for (int i = first; i <= last; i++) begin
      expect_row(i);
      req_valid_i <= 1'b1;
      req_op_i    <= tbl_op[i];
      req_addr_i  <= tbl_addr[i];
      req_data_i  <= tbl_data[i];
      accepted = 1'b0;
      while (!accepted) begin
        @(negedge hb_clk_i);
        accepted = req_ready_o;
        @(posedge hb_clk_i);
      end
    end
    req_valid_i <= 1'b0;
  endtask

  task automatic wait_drain();
    while (rsp_q.size() != 0 || flit_q.size() != 0) begin
      @(posedge hb_clk_i);
    end
  endtask

  task automatic check_ready(input logic exp, input int cycles);
    repeat (cycles) begin
      @(negedge hb_clk_i);
      if (req_ready_o !== exp) begin
        err_mismatch++;
        $display("mismatch req_ready_o: expected %h, got %h", exp, req_ready_o);
      end
    end
    @(posedge hb_clk_i);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Output checks and back-pressure
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge hb_clk_i) begin
    if (rst_n_i && rsp_valid_o && rsp_ready_i) begin
      if (rsp_q.size() == 0) begin
        err_other++;
        $display("unexpected response with data %h", rsp_data_o);
      end else begin
        rsp_exp = rsp_q.pop_front();
        if (rsp_data_o !== rsp_exp) begin
          err_mismatch++;
          $display("mismatch rsp_data_o: expected %h, got %h", rsp_exp, rsp_data_o);
        end
      end
    end
    if (rst_n_i && mem_valid_o && mem_ready_i) begin
      if (flit_q.size() == 0) begin
        err_other++;
        $display("unexpected flit to address %h", mem_addr_o);
      end else begin
        {exp_cord, exp_op, exp_addr, exp_data} = flit_q.pop_front();
        if (mem_cord_o !== exp_cord) begin
          err_mismatch++;
          $display("mismatch mem_cord_o: expected %h, got %h", exp_cord, mem_cord_o);
        end
        if (mem_op_o !== exp_op) begin
          err_mismatch++;
          $display("mismatch mem_op_o: expected %h, got %h", exp_op, mem_op_o);
        end
        if (mem_addr_o !== exp_addr) begin
          err_mismatch++;
          $display("mismatch mem_addr_o: expected %h, got %h", exp_addr, mem_addr_o);
        end
        if (mem_data_o !== exp_data) begin
          err_mismatch++;
          $display("mismatch mem_data_o: expected %h, got %h", exp_data, mem_data_o);
        end
      end
    end
  end

  // Random stall bursts of one to eight cycles per link
  always @(posedge hb_clk_i) begin
    if (!bp_en) begin
      rsp_ready_i <= 1'b1;
      mem_ready_i <= 1'b1;
      rsp_burst   <= 0;
      mem_burst   <= 0;
    end else begin
      if (rsp_burst == 0) begin
        rsp_ready_i <= ($random(seed) & 1) != 0;
        rsp_burst   <= ($random(seed) & 7) + 1;
      end else begin
        rsp_burst <= rsp_burst - 1;
      end
      if (mem_burst == 0) begin
        mem_ready_i <= ($random(seed) & 1) != 0;
        mem_burst   <= ($random(seed) & 7) + 1;
      end else begin
        mem_burst <= mem_burst - 1;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge hb_clk_i);
    $display("timeout after %0d cycles, %0d responses and %0d flits outstanding",
             WATCHDOG_CYCLES, rsp_q.size(), flit_q.size());
    $display("Verification failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    hb_clk_i     = 1'b0;
    rst_n_i      = 1'b0;
    tag_valid_i  = 1'b0;
    tag_data_i   = 1'b0;
    req_valid_i  = 1'b0;
    req_op_i     = '0;
    req_addr_i   = '0;
    req_data_i   = '0;
    rsp_ready_i  = 1'b1;
    mem_ready_i  = 1'b1;
    bp_en        = 1'b0;
    rsp_burst    = 0;
    mem_burst    = 0;
    err_mismatch = 0;
    err_other    = 0;
    seed         = 32'h6995;
    west_model   = '0;
    east_model   = '0;
    for (int w = 0; w < MEM_WORDS; w++) begin
      model_mem[w] = '0;
    end
    build_table();

    repeat (8) @(posedge hb_clk_i);
    rst_n_i <= 1'b1;

    // Core held in reset until the tag line releases it
    repeat (20) begin
      @(negedge hb_clk_i);
      if (req_ready_o !== 1'b0 || rsp_valid_o !== 1'b0 || mem_valid_o !== 1'b0) begin
        err_other++;
        $display("link outputs active while the core is still in reset");
      end
    end
    @(posedge hb_clk_i);
    send_tag(TAG_CORE_RESET, 8'h00, TAG_FRAME_LEN);
    check_ready(1'b1, 1);

    apply_rows(A_LO, A_HI);
    wait_drain();

    send_tag(TAG_WEST_CORD, 8'h05, TAG_FRAME_LEN);
    send_tag(TAG_EAST_CORD, 8'h0A, TAG_FRAME_LEN);
    apply_rows(A_HI + 1, B_HI);
    wait_drain();

    bp_en <= 1'b1;
    apply_rows(B_HI + 1, C_HI);
    bp_en <= 1'b0;
    wait_drain();

    // Cut short, east cord keeps its value
    send_tag(TAG_EAST_CORD, 8'h0C, 6);
    apply_rows(C_HI + 1, D_MID);
    wait_drain();
    send_tag(TAG_EAST_CORD, 8'h03, TAG_FRAME_LEN);
    apply_rows(D_MID + 1, D_HI);
    wait_drain();

    send_tag(TAG_CORE_RESET, 8'h01, TAG_FRAME_LEN);
    check_ready(1'b0, 4);
    send_tag(TAG_CORE_RESET, 8'h00, TAG_FRAME_LEN);
    apply_rows(D_HI + 1, N_ROWS - 1);
    wait_drain();

    repeat (10) @(posedge hb_clk_i);
    $display("errors: %0d mismatches, %0d other", err_mismatch, err_other);
    if (err_mismatch == 0 && err_other == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: hb_core_complex.f
src/hb_pkg.sv
src/hb_link_if.sv
src/hb_tag_client.sv
src/hb_link_ingress.sv
src/hb_tile_pod.sv
src/hb_link_egress.sv
src/hb_core_complex.sv
verif/tb_hb_core_complex.sv

// File: Bender.yml
package:
  name: hb_core_complex

sources:
  - src/hb_pkg.sv
  - src/hb_link_if.sv
  - src/hb_tag_client.sv
  - src/hb_link_ingress.sv
  - src/hb_tile_pod.sv
  - src/hb_link_egress.sv
  - src/hb_core_complex.sv
  - target: test
    files:
      - verif/tb_hb_core_complex.sv
